/* hdl/mont_defines.svh */
`ifndef MONT_DEFINES_SVH
`define MONT_DEFINES_SVH

// operand width W, kept even so the radix-4 loop covers all of A
`define MONT_WIDTH 64

// accumulator width, C + 3B + 3M stays below 2^(W+3)
`define MONT_ACC_WIDTH (`MONT_WIDTH + 3)

// two bits of A per iteration
`define MONT_ITERATIONS (`MONT_WIDTH / 2)

// wide enough to hold the iteration count itself
`define MONT_COUNT_WIDTH ($clog2(`MONT_ITERATIONS) + 1)

`endif

/* hdl/mont_pkg.sv */
`default_nettype none

package mont_pkg;

    // top level controller states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_PREP,
        SEQ_LOOP,
        SEQ_REDUCE,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        BANK_HOLD,
        BANK_LOAD,   // capture A, B, M
        BANK_PREP,   // register 2B, 3B, 2M, 3M
        BANK_SHIFT   // next digit of A
    } bank_op_t;

    typedef enum logic [1:0] {
        ACC_HOLD,
        ACC_CLEAR,
        ACC_STEP,    // one radix-4 iteration
        ACC_REDUCE   // final conditional subtract
    } acc_op_t;

endpackage

`default_nettype wire

/* hdl/mont_operand_if.sv */
`default_nettype none
`include "mont_defines.svh"

// operand multiples and current A digit, bank to accumulator
interface mont_operand_if;

    logic [`MONT_WIDTH+1:0] b1;
    logic [`MONT_WIDTH+1:0] b2;
    logic [`MONT_WIDTH+1:0] b3;
    logic [`MONT_WIDTH+1:0] m1;
    logic [`MONT_WIDTH+1:0] m2;
    logic [`MONT_WIDTH+1:0] m3;
    logic [1:0]             a_digit;  // two low bits of the shifting A

    modport bank (
        output b1, b2, b3,
        output m1, m2, m3,
        output a_digit
    );

    modport accum (
        input b1, b2, b3,
        input m1, m2, m3,
        input a_digit
    );

endinterface

`default_nettype wire

/* hdl/mont_operand_bank.sv */
`default_nettype none
`include "mont_defines.svh"

module mont_operand_bank (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire mont_pkg::bank_op_t      op,
    input  wire [`MONT_WIDTH-1:0]        in_a,
    input  wire [`MONT_WIDTH-1:0]        in_b,
    input  wire [`MONT_WIDTH-1:0]        in_m,
    mont_operand_if.bank                 ops
);
    import mont_pkg::*;

    logic [`MONT_WIDTH-1:0] a_shift;   // A consumed two bits at a time
    logic [`MONT_WIDTH+1:0] b_reg;
    logic [`MONT_WIDTH+1:0] b2_reg;
    logic [`MONT_WIDTH+1:0] b3_reg;
    logic [`MONT_WIDTH+1:0] m_reg;
    logic [`MONT_WIDTH+1:0] m2_reg;
    logic [`MONT_WIDTH+1:0] m3_reg;

    // doubled operands for the prep step
    logic [`MONT_WIDTH+1:0] b_x2;
    logic [`MONT_WIDTH+1:0] m_x2;

    assign b_x2 = {b_reg[`MONT_WIDTH:0], 1'b0};
    assign m_x2 = {m_reg[`MONT_WIDTH:0], 1'b0};

    // operand registers loaded on start and stepped in the loop
    always_ff @(posedge clk) begin
        case (op)
            BANK_LOAD: begin
                a_shift <= in_a;
                b_reg   <= {2'b00, in_b};
                m_reg   <= {2'b00, in_m};
            end
            BANK_PREP: begin
                b2_reg <= b_x2;
                b3_reg <= b_reg + b_x2;   // 3B < 2^(W+2)
                m2_reg <= m_x2;
                m3_reg <= m_reg + m_x2;
            end
            BANK_SHIFT: begin
                a_shift <= {2'b00, a_shift[`MONT_WIDTH-1:2]};
            end
            default: begin
            end
        endcase
    end

    assign ops.b1 = b_reg;
    assign ops.b2 = b2_reg;
    assign ops.b3 = b3_reg;
    assign ops.m1 = m_reg;
    assign ops.m2 = m2_reg;
    assign ops.m3 = m3_reg;

    assign ops.a_digit = a_shift[1:0];

    // quotient digit selection in the accumulator relies on an odd modulus
    m_odd_at_prep: assert property (
        @(posedge clk) disable iff (!resetn)
        op == BANK_PREP |-> m_reg[0]
    ) else $error("modulus loaded into the bank is even");

endmodule

`default_nettype wire

/* hdl/mont_sequencer.sv */
`default_nettype none
`include "mont_defines.svh"

module mont_sequencer (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  start,
    output mont_pkg::bank_op_t   bank_op,
    output mont_pkg::acc_op_t    acc_op,
    output logic                 done
);
    import mont_pkg::*;

    seq_state_t                    state;
    logic [`MONT_COUNT_WIDTH-1:0]  count;      // loop iterations taken so far
    logic                          last_step;

    assign last_step = (count == `MONT_COUNT_WIDTH'(`MONT_ITERATIONS - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= SEQ_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= (state == SEQ_REDUCE);   // high for the one cycle in DONE

            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_PREP;
                    end
                end
                SEQ_PREP: begin
                    state <= SEQ_LOOP;
                    count <= '0;
                end
                SEQ_LOOP: begin
                    if (last_step) begin
                        state <= SEQ_REDUCE;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                SEQ_REDUCE: begin
                    state <= SEQ_DONE;
                end
                SEQ_DONE: begin
                    state <= SEQ_IDLE;   // start seen again in IDLE
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // opcodes follow the state, load fires on the start edge itself
    always_comb begin
        bank_op = BANK_HOLD;
        acc_op  = ACC_HOLD;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    bank_op = BANK_LOAD;
                    acc_op  = ACC_CLEAR;
                end
            end
            SEQ_PREP: begin
                bank_op = BANK_PREP;
            end
            SEQ_LOOP: begin
                bank_op = BANK_SHIFT;
                acc_op  = ACC_STEP;
            end
            SEQ_REDUCE: begin
                acc_op = ACC_REDUCE;
            end
            default: begin
            end
        endcase
    end

    done_only_in_done: assert property (
        @(posedge clk) disable iff (!resetn)
        done |-> state == SEQ_DONE
    ) else $error("done raised outside the DONE state");

    count_in_range: assert property (
        @(posedge clk) disable iff (!resetn)
        count <= `MONT_COUNT_WIDTH'(`MONT_ITERATIONS)
    ) else $error("iteration counter ran past the loop length");

endmodule

`default_nettype wire

/* hdl/mont_accumulator.sv */
`default_nettype none
`include "mont_defines.svh"

module mont_accumulator (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire mont_pkg::acc_op_t   op,
    mont_operand_if.accum            ops,
    output logic [`MONT_WIDTH-1:0]   result
);
    import mont_pkg::*;

    logic [`MONT_ACC_WIDTH-1:0] c_reg;      // running value, kept below 2M
    logic [`MONT_ACC_WIDTH-1:0] b_mult;
    logic [`MONT_ACC_WIDTH-1:0] m_mult;
    logic [`MONT_ACC_WIDTH-1:0] sum_b;
    logic [`MONT_ACC_WIDTH-1:0] sum_m;
    logic [`MONT_ACC_WIDTH-1:0] m_ext;
    logic [`MONT_ACC_WIDTH-1:0] c_minus_m;
    logic [1:0]                 q_digit;

    // digit of A picks 0, B, 2B or 3B
    always_comb begin
        case (ops.a_digit)
            2'd1:    b_mult = {1'b0, ops.b1};
            2'd2:    b_mult = {1'b0, ops.b2};
            2'd3:    b_mult = {1'b0, ops.b3};
            default: b_mult = '0;
        endcase
    end

    assign sum_b = c_reg + b_mult;

    // q = -sum * M^-1 mod 4, and M^-1 mod 4 equals M mod 4 for odd M
    assign q_digit = 2'd0 - sum_b[1:0] * ops.m1[1:0];

    always_comb begin
        case (q_digit)
            2'd1:    m_mult = {1'b0, ops.m1};
            2'd2:    m_mult = {1'b0, ops.m2};
            2'd3:    m_mult = {1'b0, ops.m3};
            default: m_mult = '0;
        endcase
    end

    assign sum_m = sum_b + m_mult;   // low two bits now zero

    assign m_ext     = {1'b0, ops.m1};
    assign c_minus_m = c_reg - m_ext;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            c_reg  <= '0;
            result <= '0;
        end else begin
            case (op)
                ACC_CLEAR: c_reg <= '0;
                ACC_STEP:  c_reg <= {2'b00, sum_m[`MONT_ACC_WIDTH-1:2]};   // divide by 4
                ACC_REDUCE: begin
                    if (c_reg >= m_ext) begin
                        result <= c_minus_m[`MONT_WIDTH-1:0];
                    end else begin
                        result <= c_reg[`MONT_WIDTH-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    step_divisible: assert property (
        @(posedge clk) disable iff (!resetn)
        op == ACC_STEP |-> sum_m[1:0] == 2'b00
    ) else $error("quotient digit left nonzero low bits");

    // bounds the single subtraction at reduce time
    c_below_2m: assert property (
        @(posedge clk) disable iff (!resetn)
        op == ACC_STEP |=> c_reg < {ops.m1, 1'b0}
    ) else $error("accumulator grew past 2M");

endmodule

`default_nettype wire

/* hdl/montgomery.sv */
`default_nettype none
`include "mont_defines.svh"

module montgomery (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      start,
    input  wire [`MONT_WIDTH-1:0]    in_a,
    input  wire [`MONT_WIDTH-1:0]    in_b,
    input  wire [`MONT_WIDTH-1:0]    in_m,
    output logic [`MONT_WIDTH-1:0]   result,
    output logic                     done
);
    import mont_pkg::*;

    bank_op_t bank_op;
    acc_op_t  acc_op;

    mont_operand_if ops_if ();   // multiples and A digit

    mont_sequencer u_sequencer (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .bank_op (bank_op),
        .acc_op  (acc_op),
        .done    (done)
    );

    mont_operand_bank u_bank (
        .clk    (clk),
        .resetn (resetn),
        .op     (bank_op),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .ops    (ops_if)
    );

    mont_accumulator u_accumulator (
        .clk    (clk),
        .resetn (resetn),
        .op     (acc_op),
        .ops    (ops_if),
        .result (result)
    );

endmodule

`default_nettype wire

/* test/tb_montgomery.sv */
`default_nettype none
`include "mont_defines.svh"

module tb_montgomery;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W            = `MONT_WIDTH;
    localparam int LATENCY      = `MONT_ITERATIONS + 3;   // cycle after start in which done is high
    localparam int DONE_TIMEOUT = LATENCY + 16;
    localparam int GLITCH_CYCLE = 5;                      // stray start pulse inside the loop

    logic         clk;
    logic         resetn;
    logic         start;
    logic [W-1:0] in_a;
    logic [W-1:0] in_b;
    logic [W-1:0] in_m;
    logic [W-1:0] result;
    logic         done;

    logic [W-1:0] vec_a [$];
    logic [W-1:0] vec_b [$];
    logic [W-1:0] vec_m [$];
    logic [W-1:0] vec_exp [$];

    int pass_count;
    int fail_count;
    int test_errors;   // errors in the test that is running
    bit timed_out;
    bit stim_ok;

    montgomery DUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [W-1:0] got,
                                   input logic [W-1:0] expected);
        $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED with %0d errors", name, test_errors);
        end
    endtask

    task automatic load_stimulus();
        int           fd;
        int           items;
        string        line;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] m;
        logic [W-1:0] e;
        fd = $fopen("test/mont_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/mont_stim.txt");
            stim_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;   // comment or blank
            end
            items = $sscanf(line, "%h %h %h %h", a, b, m, e);
            if (items != 4) begin
                $display("malformed stimulus line: %s", line);
                stim_ok = 1'b0;
            end else begin
                vec_a.push_back(a);
                vec_b.push_back(b);
                vec_m.push_back(m);
                vec_exp.push_back(e);
            end
        end
        $fclose(fd);
        if (vec_a.size() == 0) begin
            $display("the stimulus file holds no vectors");
            stim_ok = 1'b0;
        end
    endtask

    task automatic check_reset_state();
        test_errors = 0;
        repeat (3) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("[ERROR] %0d ns: done is %b after reset, expected 0", $time, done);
                test_errors++;
            end
            if (result !== '0) begin
                report_mismatch("result after reset", result, '0);
            end
        end
        finish_test("reset state");
    endtask

    // cycle n ends at edge n after the start edge
    // returns the cycle in which done is high
    task automatic wait_for_done(input bit glitch, output int latency);
        int edges;
        bit seen;
        edges   = 0;
        latency = 0;
        seen    = 1'b0;
        while (!seen && !timed_out) begin
            @(posedge clk);
            edges++;
            if (glitch) begin
                start <= (edges == GLITCH_CYCLE);   // must be ignored mid-run
            end
            @(negedge clk);
            if (done === 1'b1) begin
                seen    = 1'b1;
                latency = edges + 1;   // done raised at this edge is high until the next
            end else if (edges >= DONE_TIMEOUT) begin
                $display("timeout: done did not rise within %0d cycles of start", DONE_TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic idle_gap(input logic [W-1:0] expected);
        int gap;
        gap = $urandom % 6;
        repeat (gap) begin
            @(negedge clk);
            if (result !== expected) begin
                report_mismatch("result while idle", result, expected);
            end
        end
    endtask

    task automatic run_vector(input int idx, input bit preloaded, input bit hold_next);
        int    latency;
        string name;
        test_errors = 0;
        name = $sformatf("vector %0d", idx);
        if (!preloaded) begin
            @(posedge clk);
            in_a  <= vec_a[idx];
            in_b  <= vec_b[idx];
            in_m  <= vec_m[idx];
            start <= 1'b1;
        end
        @(posedge clk);   // start edge where the bank captures operands
        if (hold_next) begin
            in_a <= vec_a[idx+1];   // start stays high into the next run
            in_b <= vec_b[idx+1];
            in_m <= vec_m[idx+1];
        end else begin
            start <= 1'b0;
            in_a  <= ~vec_a[idx];   // inverted operands the bank must ignore
            in_b  <= ~vec_b[idx];
            in_m  <= ~vec_m[idx];
        end
        wait_for_done(!hold_next, latency);
        if (timed_out) begin
            fail_count++;
            $display("%s: FAILED, no done pulse", name);
            return;
        end
        if (latency != LATENCY) begin
            $display("[ERROR] %0d ns: done high in cycle %0d after start, expected %0d",
                     $time, latency, LATENCY);
            test_errors++;
        end
        if (result !== vec_exp[idx]) begin
            report_mismatch("result", result, vec_exp[idx]);
        end
        @(posedge clk);
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("[ERROR] %0d ns: done stayed high a second cycle", $time);
            test_errors++;
        end
        if (result !== vec_exp[idx]) begin
            report_mismatch("result after done", result, vec_exp[idx]);
        end
        if (!hold_next) begin
            idle_gap(vec_exp[idx]);
        end
        finish_test(name);
    endtask

    initial begin
        bit preloaded;
        bit hold_next;
        clk         = 1'b0;
        resetn      = 1'b0;
        start       = 1'b0;
        in_a        = '0;
        in_b        = '0;
        in_m        = '0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        stim_ok     = 1'b1;
        void'($urandom(9560));

        load_stimulus();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        check_reset_state();

        if (stim_ok) begin
            preloaded = 1'b0;
            for (int i = 0; i < vec_a.size() && !timed_out; i++) begin
                // every fifth run chains straight into the next one
                hold_next = (i % 5 == 2) && (i + 1 < vec_a.size());
                run_vector(i, preloaded, hold_next);
                preloaded = hold_next;
            end
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out && stim_ok) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/mont_stim.txt */
# columns: a b m expected, all in hex, expected = a * b * 2^-64 mod m
# m = 2^64-1, 2^32+1, 65537 give 2^-64 = 1, m = 7 gives 4, m = 2^63+1 gives 2^62
0000000000000000 123456789abcdef0 ffffffffffffffff 0000000000000000
0000000000000001 0000000000000001 ffffffffffffffff 0000000000000001
0000000000000010 123456789abcdef0 ffffffffffffffff 23456789abcdef01
0000000100000000 deadbeefcafef00d ffffffffffffffff cafef00ddeadbeef
8000000000000000 0000000000000003 ffffffffffffffff 8000000000000001
fffffffffffffffe fffffffffffffffe ffffffffffffffff 0000000000000001
fffffffffffffffe 0000000000000001 ffffffffffffffff fffffffffffffffe
fffffffffffffffe 0123456789abcdef ffffffffffffffff fedcba9876543210
0000000000010000 0000000000010000 0000000100000001 0000000100000000
0000000100000000 0000000100000000 0000000100000001 0000000000000001
0000000100000000 0000000000000005 0000000100000001 00000000fffffffc
0000000000010000 0000000000010000 0000000000010001 0000000000000001
0000000000000003 0000000000001234 0000000000010001 000000000000369c
000000000000ffff 0000000000008000 0000000000010001 0000000000000001
0000000000000003 0000000000000005 0000000000000007 0000000000000004
0000000000000006 0000000000000006 0000000000000007 0000000000000004
0000000000000001 0000000000000001 0000000000000007 0000000000000004
0000000000000002 0000000000000003 0000000000000007 0000000000000003
0000000000000001 0000000000000001 8000000000000001 4000000000000000
0000000000000002 0000000000000001 8000000000000001 8000000000000000
0000000000000004 0000000000000004 8000000000000001 7ffffffffffffff9
8000000000000000 8000000000000000 8000000000000001 4000000000000000
0000000000000002 0000000000000002 0000000000000003 0000000000000001

/* all.f */
+incdir+hdl
hdl/mont_pkg.sv
hdl/mont_operand_if.sv
hdl/mont_operand_bank.sv
hdl/mont_sequencer.sv
hdl/mont_accumulator.sv
hdl/montgomery.sv
test/tb_montgomery.sv

/* run_sim.sh */
#!/bin/sh
# build the Montgomery multiplier testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_montgomery --Mdir obj_dir -o tb_montgomery
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_montgomery > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
